// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// ########################################
	// instruction encodings
	// ########################################

	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_beq   = 6'b000100,
		op_ori   = 6'b001101,
		op_lui   = 6'b001111,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} op_e;

	typedef enum logic [5:0] {
		funct_sll  = 6'b000000, // all zero word is the nop.
		funct_addu = 6'b100001,
		funct_subu = 6'b100011
	} funct_e;

	typedef enum logic [7:0] {
		kind_addu    = 8'd0,
		kind_subu    = 8'd1,
		kind_lui     = 8'd2,
		kind_ori     = 8'd3,
		kind_lw      = 8'd4,
		kind_sw      = 8'd5,
		kind_beq     = 8'd6,
		kind_nop     = 8'd7,
		kind_unknown = 8'd8
	} instr_kind_e;

	// ########################################
	// datapath control encodings
	// ########################################

	typedef enum logic [4:0] {
		alu_add = 5'd0,
		alu_sub = 5'd1,
		alu_or  = 5'd2
	} alu_op_e;

	typedef enum logic [1:0] {
		ext_unsigned = 2'd0,
		ext_signed   = 2'd1,
		ext_pad      = 2'd2 // imm goes to the upper half.
	} ext_mode_e;

	typedef enum logic {
		waddr_rt = 1'b0,
		waddr_rd = 1'b1
	} rf_waddr_sel_e;

	typedef enum logic {
		wdata_alu = 1'b0,
		wdata_mem = 1'b1
	} wdata_sel_e;

	typedef enum logic {
		alu_b_rf  = 1'b0,
		alu_b_imm = 1'b1
	} alu_b_sel_e;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        branch,
	input  logic        zero,
	input  logic [15:0] imm,
	output logic [31:0] pc
);

	logic [31:0] pc_plus4;
	logic [31:0] br_offset;
	logic [31:0] br_target;
	logic        taken;
	logic [31:0] pc_next;

	// ########################################
	// next pc
	// ########################################

	assign pc_plus4  = pc + 32'd4;
	assign br_offset = {{14{imm[15]}}, imm, 2'b00}; // word offset, sign extended.
	assign br_target = pc_plus4 + br_offset; // relative to the delay slot address.
	assign taken     = branch & zero;
	assign pc_next   = taken ? br_target : pc_plus4;

	// ########################################
	// pc register
	// ########################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/control.sv ====
`default_nettype none

module control (
	input  logic                    rst_n,
	input  mips_pkg::instr_u        instr,
	output mips_pkg::alu_op_e       alu_op,
	output mips_pkg::ext_mode_e     ext_mode,
	output mips_pkg::alu_b_sel_e    alu_b_sel,
	output mips_pkg::rf_waddr_sel_e waddr_sel,
	output mips_pkg::wdata_sel_e    wdata_sel,
	output logic                    branch,
	output logic                    rf_we,
	output logic                    dm_we
);

	import mips_pkg::*;

	instr_kind_e kind;
	logic        rtype;
	logic        rf_we_raw;
	logic        dm_we_raw;

	// ########################################
	// instruction kind
	// ########################################

	assign rtype = (instr.r.op == op_rtype);

	always_comb begin
		if (rtype && instr.r.funct == funct_addu) begin
			kind = kind_addu;
		end else if (rtype && instr.r.funct == funct_subu) begin
			kind = kind_subu;
		end else if (instr.i.op == op_lui) begin
			kind = kind_lui;
		end else if (instr.i.op == op_ori) begin
			kind = kind_ori;
		end else if (instr.i.op == op_lw) begin
			kind = kind_lw;
		end else if (instr.i.op == op_sw) begin
			kind = kind_sw;
		end else if (instr.i.op == op_beq) begin
			kind = kind_beq;
		end else if (rtype && instr.r.funct == funct_sll) begin
			kind = kind_nop;
		end else begin
			kind = kind_unknown;
		end
	end

	// ########################################
	// control word
	// ########################################

	always_comb begin
		alu_op    = alu_or; // nop and unknown fall through these.
		ext_mode  = ext_unsigned;
		alu_b_sel = alu_b_rf;
		waddr_sel = waddr_rt;
		wdata_sel = wdata_alu;
		branch    = 1'b0;
		rf_we_raw = 1'b0;
		dm_we_raw = 1'b0;
		case (kind)
			kind_addu, kind_subu: begin
				alu_op    = (kind == kind_addu) ? alu_add : alu_sub;
				waddr_sel = waddr_rd;
				rf_we_raw = 1'b1;
			end
			kind_lui, kind_ori: begin
				ext_mode  = (kind == kind_lui) ? ext_pad : ext_unsigned;
				alu_b_sel = alu_b_imm;
				rf_we_raw = 1'b1;
			end
			kind_lw, kind_sw: begin
				alu_op    = alu_add;
				ext_mode  = ext_signed;
				alu_b_sel = alu_b_imm;
				wdata_sel = wdata_mem;
				rf_we_raw = (kind == kind_lw);
				dm_we_raw = (kind == kind_sw);
			end
			kind_beq: begin
				alu_op = alu_sub; // zero flag then means rs == rt.
				branch = 1'b1;
			end
			default: ;
		endcase
	end

	// no architectural writes while in reset.
	assign rf_we = rst_n & rf_we_raw;
	assign dm_we = rst_n & dm_we_raw;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && waddr != 5'd0) begin // $zero is not writable.
			regs[waddr] <= wdata;
		end
	end

	// read ports are combinational.
	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
`default_nettype none

module execute (
	input  logic [31:0]          a,
	input  logic [31:0]          rf_b,
	input  logic [15:0]          imm,
	input  mips_pkg::ext_mode_e  ext_mode,
	input  mips_pkg::alu_b_sel_e alu_b_sel,
	input  mips_pkg::alu_op_e    alu_op,
	output logic [31:0]          result,
	output logic                 zero
);

	import mips_pkg::*;

	logic [31:0] ext_imm;
	logic [31:0] b;

	// ########################################
	// immediate extension
	// ########################################

	always_comb begin
		case (ext_mode)
			ext_signed: ext_imm = {{16{imm[15]}}, imm};
			ext_pad:    ext_imm = {imm, 16'h0000}; // lui.
			default:    ext_imm = {16'h0000, imm};
		endcase
	end

	assign b = (alu_b_sel == alu_b_imm) ? ext_imm : rf_b;

	// ########################################
	// alu
	// ########################################

	always_comb begin
		case (alu_op)
			alu_add: result = a + b; // wraps, no overflow trap.
			alu_sub: result = a - b;
			default: result = a | b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
`default_nettype none

module data_mem #(
	parameter int DM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 we,
	input  logic [31:0]          addr,
	input  logic [31:0]          wdata,
	input  logic [31:0]          alu_result,
	input  mips_pkg::wdata_sel_e wdata_sel,
	output logic [31:0]          wb_data
);

	import mips_pkg::*;

	localparam int AW = $clog2(DM_WORDS);

	logic [31:0]   mem [DM_WORDS];
	logic [AW-1:0] idx;
	logic [31:0]   rdata;

	assign idx = addr[AW+1:2]; // word address, wraps at the top.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DM_WORDS; i++) begin
				mem[i] <= 32'd0;
			end
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata   = mem[idx];
	assign wb_data = (wdata_sel == wdata_mem) ? rdata : alu_result;

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`default_nettype none

module mips_core #(
	parameter logic [31:0] RESET_PC = 32'h0000_3000,
	parameter int          DM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output logic [31:0] retire_pc,
	output logic        rf_we,
	output logic [4:0]  rf_waddr,
	output logic [31:0] rf_wdata,
	output logic        dm_we,
	output logic [31:0] dm_addr,
	output logic [31:0] dm_wdata
);

	import mips_pkg::*;

	instr_u        instr;
	logic [31:0]   pc;
	alu_op_e       alu_op;
	ext_mode_e     ext_mode;
	alu_b_sel_e    alu_b_sel;
	rf_waddr_sel_e waddr_sel;
	wdata_sel_e    wdata_sel;
	logic          branch;
	logic          zero;
	logic [31:0]   rdata1;
	logic [31:0]   rdata2;
	logic [31:0]   alu_result;
	logic [31:0]   wb_data;

	assign instr = imem_data;

	// ########################################
	// input side
	// ########################################

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk    (clk),
		.rst_n  (rst_n),
		.branch (branch),
		.zero   (zero),
		.imm    (instr.i.imm),
		.pc     (pc)
	);

	assign imem_addr = pc;
	assign retire_pc = pc; // one instruction per cycle.

	// ########################################
	// processing
	// ########################################

	control u_control (
		.rst_n     (rst_n),
		.instr     (instr),
		.alu_op    (alu_op),
		.ext_mode  (ext_mode),
		.alu_b_sel (alu_b_sel),
		.waddr_sel (waddr_sel),
		.wdata_sel (wdata_sel),
		.branch    (branch),
		.rf_we     (rf_we),
		.dm_we     (dm_we)
	);

	assign rf_waddr = (waddr_sel == waddr_rd) ? instr.r.rd : instr.r.rt;

	reg_file u_rf (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (instr.i.rs),
		.raddr2 (instr.i.rt),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (rf_we),
		.waddr  (rf_waddr),
		.wdata  (wb_data)
	);

	execute u_exec (
		.a         (rdata1),
		.rf_b      (rdata2),
		.imm       (instr.i.imm),
		.ext_mode  (ext_mode),
		.alu_b_sel (alu_b_sel),
		.alu_op    (alu_op),
		.result    (alu_result),
		.zero      (zero)
	);

	// ########################################
	// output side
	// ########################################

	data_mem #(
		.DM_WORDS (DM_WORDS)
	) u_dm (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (dm_we),
		.addr       (alu_result),
		.wdata      (rdata2),
		.alu_result (alu_result),
		.wdata_sel  (wdata_sel),
		.wb_data    (wb_data)
	);

	assign rf_wdata = wb_data;
	assign dm_addr  = alu_result;
	assign dm_wdata = rdata2;

endmodule

`default_nettype wire

// ==== dv/mips_asserts.sv ====
`default_nettype none

module mips_checker (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] imem_data,
	input logic [31:0] retire_pc,
	input logic        rf_we,
	input logic [4:0]  rf_waddr,
	input logic        dm_we
);

	timeunit 1ns;
	timeprecision 100ps;

	import mips_pkg::*;

	int unsigned fail_count = 0;
	logic [31:0] br_step;

	assign br_step = {{14{imem_data[15]}}, imem_data[15:0], 2'b00} + 32'd4; // taken beq step.

	// ########################################
	// port checks
	// ########################################

	assert property (@(posedge clk) !rst_n |-> (!rf_we && !dm_we))
	else begin
		$error("write enable active while the core is in reset");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) rf_we |-> (rf_waddr != 5'd0))
	else begin
		$error("register write aimed at register zero");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (retire_pc == $past(retire_pc) + 32'd4) ||
			($past(imem_data[31:26]) == op_beq &&
			retire_pc == $past(retire_pc) + $past(br_step)))
	else begin
		$error("retire_pc moved by a step that is neither 4 nor a branch offset");
		fail_count++;
	end

endmodule

bind mips_core mips_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.imem_data (imem_data),
	.retire_pc (retire_pc),
	.rf_we     (rf_we),
	.rf_waddr  (rf_waddr),
	.dm_we     (dm_we)
);

`default_nettype wire

// ==== dv/mips_tb.sv ====
`default_nettype none

module mips_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import mips_pkg::*;

	localparam logic [31:0] RESET_PC       = 32'h0000_3000;
	localparam int          DM_WORDS       = 256;
	localparam int          PROG_WORDS     = 32;
	localparam int          PROG_TOTAL     = 8 + 12 + 15 + 8 + 6 + 6; // words over all tests.
	localparam int          TIMEOUT_CYCLES = 2 * PROG_TOTAL + 20;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] retire_pc;
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;
	logic        dm_we;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;

	logic [31:0] prog [PROG_WORDS];
	logic [31:0] imem_idx;
	int          nprog;
	logic [31:0] lfsr_state = 32'h4efb2d4b;
	logic [31:0] mregs [32];
	logic [31:0] mmem [DM_WORDS];
	logic [31:0] model_pc;
	int          errors = 0;
	int          cycles = 0;
	int          tests_failed = 0;
	int          mark = 0;

	mips_core #(
		.RESET_PC (RESET_PC),
		.DM_WORDS (DM_WORDS)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.retire_pc (retire_pc),
		.rf_we     (rf_we),
		.rf_waddr  (rf_waddr),
		.rf_wdata  (rf_wdata),
		.dm_we     (dm_we),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata)
	);

	// program memory answers in the same cycle.
	always_comb begin
		imem_idx  = (imem_addr - RESET_PC) >> 2;
		imem_data = (imem_idx < PROG_WORDS) ? prog[imem_idx[4:0]] : 32'h0;
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the programs did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// ########################################
	// stimulus helpers
	// ########################################

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [4:0] r;
		r = 5'(rand_bits(5));
		return (r == 5'd0) ? 5'd1 : r; // keeps $zero out of write targets.
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		instr_u w;
		w.r.op    = op_rtype;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = 5'd0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input op_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i.op  = op;
		w.i.rs  = rs;
		w.i.rt  = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] end_pc();
		return RESET_PC + 32'(4 * nprog);
	endfunction

	function automatic int total_errors();
		return errors + int'(dut.u_checker.fail_count);
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[nprog] = word;
		nprog++;
	endtask

	task automatic clear_program();
		for (int k = 0; k < PROG_WORDS; k++) begin
			prog[k] = 32'h0;
		end
		nprog = 0;
	endtask

	task automatic reset_model();
		for (int k = 0; k < 32; k++) begin
			mregs[k] = 32'd0;
		end
		for (int k = 0; k < DM_WORDS; k++) begin
			mmem[k] = 32'd0;
		end
		model_pc = RESET_PC;
	endtask

	task automatic start_reset();
		@(negedge clk);
		rst_n = 1'b0;
		reset_model();
	endtask

	task automatic finish_reset();
		repeat (2) begin
			@(posedge clk);
			assert (!rf_we && !dm_we) else begin
				$display("ERROR %0t: write enable seen during reset", $time);
				errors++;
			end
		end
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ########################################
	// reference model
	// ########################################

	task automatic check_and_step();
		instr_u      iw;
		logic [31:0] widx;
		logic [31:0] rsv;
		logic [31:0] rtv;
		logic [31:0] sx;
		logic        e_rf_we;
		logic [4:0]  e_waddr;
		logic [31:0] e_wdata;
		logic        e_dm_we;
		logic [31:0] e_daddr;
		logic [31:0] e_ddata;
		logic [31:0] next_pc;
		widx    = (model_pc - RESET_PC) >> 2;
		iw      = (widx < PROG_WORDS) ? prog[widx[4:0]] : 32'h0;
		rsv     = mregs[iw.i.rs];
		rtv     = mregs[iw.i.rt];
		sx      = {{16{iw.i.imm[15]}}, iw.i.imm};
		e_rf_we = 1'b0;
		e_waddr = iw.i.rt;
		e_wdata = 32'd0;
		e_dm_we = 1'b0;
		e_daddr = rsv + sx;
		e_ddata = rtv;
		next_pc = model_pc + 32'd4;
		case (iw.i.op)
			op_rtype: begin
				if (iw.r.funct == funct_addu || iw.r.funct == funct_subu) begin
					e_rf_we = 1'b1;
					e_waddr = iw.r.rd;
					e_wdata = (iw.r.funct == funct_addu) ? rsv + rtv : rsv - rtv;
				end
			end
			op_ori: begin
				e_rf_we = 1'b1;
				e_wdata = rsv | {16'h0000, iw.i.imm};
			end
			op_lui: begin
				e_rf_we = 1'b1;
				e_wdata = {iw.i.imm, 16'h0000};
			end
			op_lw: begin
				e_rf_we = 1'b1;
				e_wdata = mmem[(e_daddr >> 2) % DM_WORDS];
			end
			op_sw: e_dm_we = 1'b1;
			op_beq: begin
				if (rsv == rtv) begin
					next_pc = model_pc + 32'd4 + (sx << 2);
				end
			end
			default: ;
		endcase
		check_value("retire_pc", retire_pc, model_pc);
		check_value("imem_addr", imem_addr, model_pc);
		check_value("rf_we", {31'd0, rf_we}, {31'd0, e_rf_we});
		check_value("dm_we", {31'd0, dm_we}, {31'd0, e_dm_we});
		if (e_rf_we) begin
			check_value("rf_waddr", {27'd0, rf_waddr}, {27'd0, e_waddr});
			check_value("rf_wdata", rf_wdata, e_wdata);
			if (e_waddr != 5'd0) mregs[e_waddr] = e_wdata;
		end
		if (e_dm_we) begin
			check_value("dm_addr", dm_addr, e_daddr);
			check_value("dm_wdata", dm_wdata, e_ddata);
			mmem[(e_daddr >> 2) % DM_WORDS] = e_ddata;
		end
		model_pc = next_pc;
	endtask

	task automatic run_program(input logic [31:0] stop_pc);
		@(posedge clk);
		while (retire_pc != stop_pc) begin
			check_and_step();
			@(posedge clk);
		end
	endtask

	task automatic report_test(input string name);
		if (total_errors() == mark) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name, total_errors() - mark);
			tests_failed++;
		end
		mark = total_errors();
	endtask

	// ########################################
	// test sequence
	// ########################################

	initial begin
		logic [4:0]  rb;
		logic [4:0]  rv;
		logic [4:0]  r [4];
		logic [15:0] v;
		logic [15:0] base;
		logic [15:0] off;
		rst_n = 1'b0;
		clear_program();
		reset_model();

		for (int k = 0; k < 8; k++) begin
			v = 16'(rand_bits(16));
			emit(enc_i((k % 2 == 0) ? op_ori : op_lui, 5'd0, rand_reg(), v));
		end
		finish_reset();
		run_program(end_pc());
		report_test("ori_lui");

		start_reset();
		clear_program();
		for (int k = 0; k < 4; k++) begin
			r[k] = rand_reg();
			emit(enc_i(op_lui, 5'd0, r[k], 16'(rand_bits(16))));
			emit(enc_i(op_ori, r[k], r[k], 16'(rand_bits(16))));
		end
		for (int k = 0; k < 4; k++) begin
			emit(enc_r((k % 2 == 0) ? funct_addu : funct_subu, r[2'(rand_bits(2))],
				r[2'(rand_bits(2))], rand_reg()));
		end
		finish_reset();
		run_program(end_pc());
		report_test("addu_subu");

		start_reset();
		clear_program();
		for (int k = 0; k < 3; k++) begin
			rb   = rand_reg();
			rv   = (rb == 5'd31) ? 5'd1 : rb + 5'd1;
			base = 16'(rand_bits(8) << 2);
			off  = 16'(rand_bits(14) << 2); // signed, word aligned.
			emit(enc_i(op_ori, 5'd0, rb, base));
			emit(enc_i(op_lui, 5'd0, rv, 16'(rand_bits(16))));
			emit(enc_i(op_ori, rv, rv, 16'(rand_bits(16))));
			emit(enc_i(op_sw, rb, rv, off));
			emit(enc_i(op_lw, rb, rand_reg(), off));
		end
		finish_reset();
		run_program(end_pc());
		report_test("sw_lw");

		start_reset();
		clear_program();
		v = 16'(rand_bits(16));
		emit(enc_i(op_ori, 5'd0, 5'd1, v));
		emit(enc_i(op_ori, 5'd0, 5'd2, v));
		emit(enc_i(op_ori, 5'd0, 5'd3, v ^ 16'h0001));
		emit(enc_i(op_beq, 5'd1, 5'd2, 16'd2)); // taken, skips two.
		emit(enc_i(op_ori, 5'd0, 5'd4, 16'd1));
		emit(enc_i(op_ori, 5'd0, 5'd4, 16'd2));
		emit(enc_i(op_beq, 5'd1, 5'd3, 16'd1)); // not taken.
		emit(32'h0);
		finish_reset();
		run_program(end_pc());
		report_test("beq");

		start_reset();
		clear_program();
		emit(32'h0);
		emit({6'b000010, 26'(rand_bits(26))});
		emit(enc_r(6'b100000, rand_reg(), rand_reg(), rand_reg()));
		emit({6'b111111, 26'(rand_bits(26))});
		emit(enc_r(6'b000000, 5'd0, rand_reg(), rand_reg()));
		emit({6'b001000, 26'(rand_bits(26))});
		finish_reset();
		run_program(end_pc());
		report_test("nop_unknown");

		start_reset();
		clear_program();
		emit(enc_i(op_sw, 5'd0, 5'd0, 16'(rand_bits(14) << 2))); // store sits at the reset pc.
		for (int k = 0; k < 5; k++) begin
			emit(enc_i(op_ori, 5'd0, rand_reg(), 16'(rand_bits(16))));
		end
		finish_reset();
		repeat (3) begin
			@(posedge clk);
			check_and_step();
		end
		start_reset();
		finish_reset();
		run_program(end_pc());
		report_test("mid_reset");

		$display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, total_errors());
		if (total_errors() == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/mips_pkg.sv
rtl/fetch_unit.sv
rtl/control.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/data_mem.sv
rtl/mips_core.sv
dv/mips_asserts.sv
dv/mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/control.sv
  - rtl/reg_file.sv
  - rtl/execute.sv
  - rtl/data_mem.sv
  - rtl/mips_core.sv
  - target: test
    files:
      - dv/mips_asserts.sv
      - dv/mips_tb.sv
